// ==== Makefile ====
TOP = tb_response_frame_builder

sim:
	verilator --binary --assert --top-module $(TOP) -f sim.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== crc8_accumulator.sv ====
`timescale 1ns/1ps

module crc8_accumulator
    import frame_pkg::*;
    import crc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  soft_reset_request,
    input  logic  frame_start,    // Clears the sum for a new frame
    input  logic  field_in_crc,   // field_byte is covered this cycle
    input  byte_t field_byte,
    output crc_t  crc_value       // Running checksum
);

    // One byte through the CRC-8, bit by bit, MSB first
    function automatic crc_t crc8_step(input crc_t crc_in, input byte_t data);
        crc_t c;
        c = crc_in ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = (c << 1) ^ CRC_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    // --------------------------------------------------
    // Checksum register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            crc_value <= CRC_INIT;
        end else if (soft_reset_request || frame_start) begin
            crc_value <= CRC_INIT;      // Fresh sum, never overlaps a covered byte
        end else if (field_in_crc) begin
            crc_value <= crc8_step(crc_value, field_byte);  // Ready one edge later
        end
    end

endmodule

// ==== crc_pkg.sv ====
package crc_pkg;

    // --------------------------------------------------
    // Frame checksum
    // --------------------------------------------------

    // CRC-8 result, same width as one frame byte
    typedef logic [7:0] crc_t;

    // x^8 + x^2 + x + 1, MSB first, no reflection
    localparam crc_t CRC_POLY = 8'h07;

    // Start value at the beginning of each frame
    // No final XOR is applied to the result
    localparam crc_t CRC_INIT = 8'h00;

    // Coverage: STATUS, CMD, address and data bytes
    // SOF is never folded in

endpackage

// ==== frame_pkg.sv ====
package frame_pkg;

    // --------------------------------------------------
    // Field types
    // --------------------------------------------------
    typedef logic [7:0]  byte_t;    // One byte on the UART link
    typedef logic [31:0] addr_t;    // AXI address echoed in read responses
    typedef logic [4:0]  count_t;   // Payload byte count, 0 to MAX_PAYLOAD

    // --------------------------------------------------
    // Frame layout
    // --------------------------------------------------
    localparam int MAX_PAYLOAD = 16;    // Largest read payload in one frame
    localparam int ADDR_BYTES  = 4;     // Address echo is sent LSB first

    // Start of frame, device to host direction
    localparam byte_t SOF_DEVICE_TO_HOST = 8'h5A;

    // RESET command gets SOF, STATUS and CMD only, no CRC
    localparam byte_t CMD_RESET = 8'hFF;

    // Status codes that count as a successful read
    // The data phase is sent only for one of these
    localparam byte_t STATUS_OK      = 8'h00;
    localparam byte_t STATUS_OK_ALT1 = 8'h40;
    localparam byte_t STATUS_OK_ALT2 = 8'h80;

endpackage

// ==== frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer
    import frame_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    soft_reset_request,  // Pulse, aborts the frame
    input  logic                    build_response,      // Rising edge starts a frame
    input  byte_t                   status_code,
    input  byte_t                   cmd_echo,
    input  addr_t                   addr_echo,
    input  byte_t [MAX_PAYLOAD-1:0] response_data,       // Byte 0 in the low bits
    input  count_t                  response_data_count,
    input  logic                    tx_fifo_full,
    output byte_t                   field_byte,          // Byte for the current field
    output logic                    field_write,         // Byte chosen this cycle
    output logic                    field_in_crc,        // Byte goes into the checksum
    output logic                    field_is_crc,        // Send CRC instead of field_byte
    output logic                    frame_start,         // One cycle after accept
    output logic                    builder_busy,
    output logic                    response_complete
);

    // Field order of a response frame
    typedef enum logic [3:0] {
        IDLE,
        SOF,
        STATUS,
        CMD,
        ADDR0,
        ADDR1,
        ADDR2,
        ADDR3,
        DATA,
        CRC,
        DONE,
        GAP
    } frame_state_t;

    frame_state_t state;
    frame_state_t state_next;

    logic   build_prev;     // build_response at the previous edge
    logic   start_accept;   // Rising edge seen while idle
    logic   status_ok;      // Latched status is a success code
    logic   byte_state;     // State that emits a byte
    logic   last_data;      // Current data byte is the final one
    count_t count_clamped;  // Input count limited to MAX_PAYLOAD
    count_t data_index;     // Next payload byte, moves on chosen bytes only

    // Latched request, held for the whole frame
    byte_t                   status_reg;
    byte_t                   cmd_reg;
    byte_t [ADDR_BYTES-1:0]  addr_reg;     // Index 0 is the LSB
    byte_t [MAX_PAYLOAD-1:0] data_reg;
    count_t                  count_reg;

    // --------------------------------------------------
    // Start detect and request latch
    // --------------------------------------------------
    assign start_accept = build_response && !build_prev && (state == IDLE);

    // Oversized counts are cut to the payload maximum
    assign count_clamped = (response_data_count > count_t'(MAX_PAYLOAD)) ?
                           count_t'(MAX_PAYLOAD) : response_data_count;

    always_ff @(posedge clk) begin
        if (start_accept) begin
            status_reg <= status_code;
            cmd_reg    <= cmd_echo;
            addr_reg   <= addr_echo;      // Packed copy keeps LSB in byte 0
            data_reg   <= response_data;
            count_reg  <= count_clamped;
        end
    end

    // --------------------------------------------------
    // Decode helpers
    // --------------------------------------------------
    assign status_ok = (status_reg == STATUS_OK) ||
                       (status_reg == STATUS_OK_ALT1) ||
                       (status_reg == STATUS_OK_ALT2);

    assign byte_state = (state == SOF)   || (state == STATUS) || (state == CMD) ||
                        (state == ADDR0) || (state == ADDR1)  || (state == ADDR2) ||
                        (state == ADDR3) || (state == DATA)   || (state == CRC);

    assign last_data = ((data_index + count_t'(1)) == count_reg);

    // A byte leaves only when the FIFO has room
    assign field_write  = byte_state && !tx_fifo_full;
    assign field_in_crc = field_write && (state != SOF) && (state != CRC);  // SOF not covered
    assign field_is_crc = (state == CRC);

    assign builder_busy      = (state != IDLE);
    assign response_complete = (state == GAP);   // Cycle after the CRC write lands

    // --------------------------------------------------
    // Field byte mux
    // --------------------------------------------------
    always_comb begin
        case (state)
            SOF:     field_byte = SOF_DEVICE_TO_HOST;
            STATUS:  field_byte = status_reg;
            CMD:     field_byte = cmd_reg;
            ADDR0:   field_byte = addr_reg[0];
            ADDR1:   field_byte = addr_reg[1];
            ADDR2:   field_byte = addr_reg[2];
            ADDR3:   field_byte = addr_reg[3];
            DATA:    field_byte = data_reg[data_index[3:0]];
            default: field_byte = '0;   // CRC byte comes from the accumulator
        endcase
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;   // Hold while the FIFO is full
        case (state)
            IDLE: begin
                if (start_accept) begin
                    state_next = SOF;
                end
            end
            SOF:    if (!tx_fifo_full) state_next = STATUS;
            STATUS: if (!tx_fifo_full) state_next = CMD;
            CMD: begin
                if (!tx_fifo_full) begin
                    if (cmd_reg == CMD_RESET) begin
                        state_next = IDLE;          // No CRC, no completion pulse
                    end else if (cmd_reg[7] && status_ok) begin
                        state_next = ADDR0;         // Full read response
                    end else begin
                        state_next = CRC;           // Write or failed read
                    end
                end
            end
            ADDR0: if (!tx_fifo_full) state_next = ADDR1;
            ADDR1: if (!tx_fifo_full) state_next = ADDR2;
            ADDR2: if (!tx_fifo_full) state_next = ADDR3;
            ADDR3: begin
                if (!tx_fifo_full) begin
                    state_next = (count_reg != '0) ? DATA : CRC;  // Empty payload skips DATA
                end
            end
            DATA: begin
                if (!tx_fifo_full && last_data) begin
                    state_next = CRC;
                end
            end
            CRC:     if (!tx_fifo_full) state_next = DONE;
            DONE:    state_next = GAP;
            GAP:     state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // --------------------------------------------------
    // State and control registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            build_prev  <= 1'b0;
            frame_start <= 1'b0;
            data_index  <= '0;
        end else begin
            build_prev <= build_response;   // Tracked through soft reset too
            if (soft_reset_request) begin
                state       <= IDLE;        // Drop the partial frame
                frame_start <= 1'b0;
                data_index  <= '0;
            end else begin
                state       <= state_next;
                frame_start <= start_accept;
                if (start_accept) begin
                    data_index <= '0;
                end else if ((state == DATA) && field_write) begin
                    data_index <= data_index + count_t'(1);
                end
            end
        end
    end

endmodule

// ==== frame_testdata.txt ====
// cmd status addr count data0..data15 mode(0 plain,1 random full,2 soft reset) len crc
// len and crc in hex; len counts every written byte, crc unused for RESET and aborts
01 00 00000000 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 04 07
02 01 00000000 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 04 1B
81 00 00000000 02 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0A 55
81 40 00000000 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 08 83
81 80 00000000 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 08 19
82 00 00000001 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 08 45
81 01 00000000 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 04 9B
FF 00 00000000 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 03 00
81 00 00000000 1F 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 18 ED
81 00 00000000 1F 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 18 ED
81 00 00000000 1F 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2 00 00
01 00 00000000 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 04 07

// ==== response_frame_builder.sv ====
`timescale 1ns/1ps

module response_frame_builder
    import frame_pkg::*;
    import crc_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    soft_reset_request,
    input  logic                    build_response,
    input  byte_t                   status_code,
    input  byte_t                   cmd_echo,
    input  addr_t                   addr_echo,
    input  byte_t [MAX_PAYLOAD-1:0] response_data,
    input  count_t                  response_data_count,
    input  logic                    tx_fifo_full,
    output byte_t                   tx_fifo_data,
    output logic                    tx_fifo_wr_en,
    output logic                    builder_busy,
    output logic                    response_complete
);

    // Sequencer to CRC and output stage
    byte_t field_byte;
    logic  field_write;
    logic  field_in_crc;
    logic  field_is_crc;
    logic  frame_start;
    crc_t  crc_value;

    // --------------------------------------------------
    // Field order and flow control
    // --------------------------------------------------
    frame_sequencer i_frame_sequencer (
        .clk                 (clk),
        .rst                 (rst),
        .soft_reset_request  (soft_reset_request),
        .build_response      (build_response),
        .status_code         (status_code),
        .cmd_echo            (cmd_echo),
        .addr_echo           (addr_echo),
        .response_data       (response_data),
        .response_data_count (response_data_count),
        .tx_fifo_full        (tx_fifo_full),
        .field_byte          (field_byte),
        .field_write         (field_write),
        .field_in_crc        (field_in_crc),
        .field_is_crc        (field_is_crc),
        .frame_start         (frame_start),
        .builder_busy        (builder_busy),
        .response_complete   (response_complete)
    );

    // Checksum runs beside the sequencer
    crc8_accumulator i_crc8_accumulator (
        .clk                (clk),
        .rst                (rst),
        .soft_reset_request (soft_reset_request),
        .frame_start        (frame_start),
        .field_in_crc       (field_in_crc),
        .field_byte         (field_byte),
        .crc_value          (crc_value)
    );

    // Registered FIFO write
    tx_byte_stage i_tx_byte_stage (
        .clk                (clk),
        .rst                (rst),
        .soft_reset_request (soft_reset_request),
        .field_write        (field_write),
        .field_is_crc       (field_is_crc),
        .field_byte         (field_byte),
        .crc_value          (crc_value),
        .tx_fifo_data       (tx_fifo_data),
        .tx_fifo_wr_en      (tx_fifo_wr_en)
    );

endmodule

// ==== response_frame_builder_chk.sv ====
`timescale 1ns/1ps

module response_frame_builder_chk (
    input logic clk,
    input logic rst,
    input logic soft_reset_request,
    input logic tx_fifo_full,
    input logic tx_fifo_wr_en,
    input logic builder_busy,
    input logic response_complete
);

    // --------------------------------------------------
    // Port protocol properties
    // --------------------------------------------------

    // Completion is a one-cycle pulse
    a_complete_pulse: assert property (@(posedge clk) disable iff (rst)
        response_complete |=> !response_complete)
        else $error("response_complete held longer than one cycle");

    // A write lands one cycle after a byte was chosen with room in the FIFO
    a_write_room: assert property (@(posedge clk) disable iff (rst)
        tx_fifo_wr_en |-> !$past(tx_fifo_full))
        else $error("FIFO write without room when the byte was chosen");

    // Soft reset drops the builder straight back to idle
    a_soft_reset_idle: assert property (@(posedge clk) disable iff (rst)
        soft_reset_request |=> !builder_busy)
        else $error("builder_busy still high after soft reset");

endmodule

// Checker sits on the top level ports
bind response_frame_builder response_frame_builder_chk i_response_frame_builder_chk (.*);

// ==== sim.f ====
frame_pkg.sv
crc_pkg.sv
frame_sequencer.sv
crc8_accumulator.sv
tx_byte_stage.sv
response_frame_builder.sv
response_frame_builder_chk.sv
tb_response_frame_builder.sv

// ==== tb_response_frame_builder.sv ====
`timescale 1ns/1ps

module tb_response_frame_builder
    import frame_pkg::*;
();

    // --------------------------------------------------
    // Test table layout
    // --------------------------------------------------
    localparam int NUM_FRAMES  = 12;
    localparam int LINE_WORDS  = 23;    // Tokens per frame line in the data file
    localparam int CYCLE_LIMIT = 4 * NUM_FRAMES * (8 + MAX_PAYLOAD + 10);

    logic [31:0] testdata [0:NUM_FRAMES*LINE_WORDS-1];

    // DUT signals
    logic                    clk;
    logic                    rst;
    logic                    soft_reset_request;
    logic                    build_response;
    byte_t                   status_code;
    byte_t                   cmd_echo;
    addr_t                   addr_echo;
    byte_t [MAX_PAYLOAD-1:0] response_data;
    count_t                  response_data_count;
    logic                    tx_fifo_full;
    byte_t                   tx_fifo_data;
    logic                    tx_fifo_wr_en;
    logic                    builder_busy;
    logic                    response_complete;

    byte_t  captured[$];        // FIFO sink contents for the current frame
    int     complete_count;     // response_complete pulses seen in this frame
    int     error_count;
    int     check_count;
    int     cycle_count;
    integer seed;
    logic   backpressure_on;    // Random full enabled for this frame

    response_frame_builder i_response_frame_builder (
        .clk                 (clk),
        .rst                 (rst),
        .soft_reset_request  (soft_reset_request),
        .build_response      (build_response),
        .status_code         (status_code),
        .cmd_echo            (cmd_echo),
        .addr_echo           (addr_echo),
        .response_data       (response_data),
        .response_data_count (response_data_count),
        .tx_fifo_full        (tx_fifo_full),
        .tx_fifo_data        (tx_fifo_data),
        .tx_fifo_wr_en       (tx_fifo_wr_en),
        .builder_busy        (builder_busy),
        .response_complete   (response_complete)
    );

    // --------------------------------------------------
    // Clock, watchdog and FIFO sink
    // --------------------------------------------------
    always #4 clk = ~clk;   // 8 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!rst && tx_fifo_wr_en) captured.push_back(tx_fifo_data);   // Sink takes every write
        if (!rst && response_complete) complete_count++;
    end

    // Back-pressure is changed on the falling edge like all other inputs
    always @(negedge clk) begin
        logic [31:0] r;
        if (backpressure_on) begin
            r = $random(seed);
            tx_fifo_full <= r[0];
        end else begin
            tx_fifo_full <= 1'b0;
        end
    end

    // Compare one value and report a mismatch
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Load one line of the table onto the DUT inputs
    task automatic load_inputs(input int base);
        cmd_echo            = testdata[base][7:0];
        status_code         = testdata[base+1][7:0];
        addr_echo           = testdata[base+2];
        response_data_count = testdata[base+3][4:0];
        for (int i = 0; i < MAX_PAYLOAD; i++) begin
            response_data[i] = testdata[base+4+i][7:0];
        end
    endtask

    // Raise build_response for one cycle and wait until the SOF state is reached
    task automatic start_frame();
        captured.delete();
        complete_count = 0;
        build_response = 1'b1;
        @(negedge clk);
        build_response = 1'b0;
    endtask

    // --------------------------------------------------
    // Frame runners
    // --------------------------------------------------
    task automatic run_frame(input int idx);
        int    base;
        int    n;
        int    exp_len;
        logic  ok_read;
        byte_t exp_byte;
        base = idx * LINE_WORDS;
        load_inputs(base);
        backpressure_on <= (testdata[base+20] == 1);
        start_frame();
        check_value(32'(builder_busy), 1, "builder_busy after start");
        while (builder_busy) @(negedge clk);    // Watchdog covers a stuck frame
        backpressure_on <= 1'b0;
        repeat (2) @(negedge clk);              // Last write of a RESET frame lands here
        exp_len = testdata[base+21];
        n = (int'(response_data_count) > MAX_PAYLOAD) ? MAX_PAYLOAD :
            int'(response_data_count);
        ok_read = cmd_echo[7] && (cmd_echo != CMD_RESET) &&
                  ((status_code == STATUS_OK) || (status_code == STATUS_OK_ALT1) ||
                   (status_code == STATUS_OK_ALT2));
        check_value(captured.size(), exp_len, $sformatf("frame %0d length", idx));
        if (captured.size() != exp_len) return;     // Byte checks need the right length
        check_value(32'(captured[0]), 32'(SOF_DEVICE_TO_HOST),
                    $sformatf("frame %0d SOF", idx));
        check_value(32'(captured[1]), 32'(status_code), $sformatf("frame %0d STATUS", idx));
        check_value(32'(captured[2]), 32'(cmd_echo), $sformatf("frame %0d CMD", idx));
        if (ok_read) begin
            check_value(exp_len, 8 + n, $sformatf("frame %0d table length", idx));
            for (int i = 0; i < ADDR_BYTES; i++) begin
                exp_byte = addr_echo[8*i +: 8];     // LSB first
                check_value(32'(captured[3+i]), 32'(exp_byte),
                            $sformatf("frame %0d addr %0d", idx, i));
            end
            for (int i = 0; i < n; i++) begin
                check_value(32'(captured[7+i]), 32'(response_data[i]),
                            $sformatf("frame %0d data %0d", idx, i));
            end
        end
        if (cmd_echo == CMD_RESET) begin
            check_value(complete_count, 0, $sformatf("frame %0d completion pulses", idx));
        end else begin
            check_value(32'(captured[exp_len-1]), 32'(testdata[base+22][7:0]),
                        $sformatf("frame %0d CRC", idx));
            check_value(complete_count, 1, $sformatf("frame %0d completion pulses", idx));
        end
        check_value(32'(builder_busy), 0, $sformatf("frame %0d builder_busy at end", idx));
    endtask

    // Abort a frame part way with a soft reset
    task automatic run_abort(input int idx);
        int held;
        load_inputs(idx * LINE_WORDS);
        start_frame();
        while (captured.size() < 6) @(negedge clk);
        soft_reset_request = 1'b1;
        @(negedge clk);
        soft_reset_request = 1'b0;
        check_value(32'(builder_busy), 0, $sformatf("frame %0d busy after soft reset", idx));
        held = captured.size();
        repeat (6) @(negedge clk);
        check_value(captured.size(), held, $sformatf("frame %0d writes after abort", idx));
        check_value(complete_count, 0, $sformatf("frame %0d pulse after abort", idx));
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk                 = 1'b0;
        rst                 = 1'b1;
        soft_reset_request  = 1'b0;
        build_response      = 1'b0;
        status_code         = '0;
        cmd_echo            = '0;
        addr_echo           = '0;
        response_data       = '0;
        response_data_count = '0;
        tx_fifo_full        = 1'b0;
        backpressure_on     = 1'b0;
        complete_count      = 0;
        error_count         = 0;
        check_count         = 0;
        cycle_count         = 0;
        seed                = 56;
        $readmemh("frame_testdata.txt", testdata);
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value(32'(tx_fifo_wr_en), 0, "tx_fifo_wr_en after reset");
        check_value(32'(builder_busy), 0, "builder_busy after reset");
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (testdata[f*LINE_WORDS+20] == 2) run_abort(f);
            else run_frame(f);
            @(negedge clk);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tx_byte_stage.sv ====
`timescale 1ns/1ps

module tx_byte_stage
    import frame_pkg::*;
    import crc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  soft_reset_request,
    input  logic  field_write,    // Byte chosen this cycle
    input  logic  field_is_crc,   // Checksum byte replaces field_byte
    input  byte_t field_byte,
    input  crc_t  crc_value,
    output byte_t tx_fifo_data,
    output logic  tx_fifo_wr_en
);

    byte_t out_byte;   // Byte selected for the FIFO

    // CRC is already complete when the CRC state is reached
    assign out_byte = field_is_crc ? byte_t'(crc_value) : field_byte;

    // --------------------------------------------------
    // Output register, one cycle of latency
    // --------------------------------------------------

    // Write strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_fifo_wr_en <= 1'b0;
        end else if (soft_reset_request) begin
            tx_fifo_wr_en <= 1'b0;      // Pending write of an aborted frame is dropped
        end else begin
            tx_fifo_wr_en <= field_write;
        end
    end

    // Data follows the strobe, only meaningful with wr_en
    always_ff @(posedge clk) begin
        if (field_write) begin
            tx_fifo_data <= out_byte;
        end
    end

endmodule
